/* rv32_pkg.sv */
package rv32_pkg;

    // *************************************************************************
    // Widths
    // *************************************************************************
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // *************************************************************************
    // Instruction encodings
    // *************************************************************************
    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_e;

    localparam logic [2:0] FUNCT3_JALR    = 3'b000;

    localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
    localparam logic [2:0] FUNCT3_BNE     = 3'b001;
    localparam logic [2:0] FUNCT3_BLT     = 3'b100;
    localparam logic [2:0] FUNCT3_BGE     = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU    = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU    = 3'b111;

    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    localparam logic [6:0] FUNCT7_ZERO    = 7'b0000000;
    localparam logic [6:0] FUNCT7_SUB_SRA = 7'b0100000;

    // *************************************************************************
    // Execute stage control
    // *************************************************************************
    typedef enum logic [3:0] {
        ALU_OP_ADD_SUB = 4'd0,
        ALU_OP_SLL     = 4'd1,
        ALU_OP_SLT     = 4'd2,
        ALU_OP_SLTU    = 4'd3,
        ALU_OP_XOR     = 4'd4,
        ALU_OP_SRL_SRA = 4'd5,
        ALU_OP_OR      = 4'd6,
        ALU_OP_AND     = 4'd7,
        ALU_OP_SRC2    = 4'd8,
        ALU_OP_SRC1P4  = 4'd9
    } alu_op_e;

    typedef enum logic {ALU_SRC1_REG = 1'b0, ALU_SRC1_PC = 1'b1} alu_src1_e;
    typedef enum logic {ALU_SRC2_REG = 1'b0, ALU_SRC2_IMM = 1'b1} alu_src2_e;

    typedef enum logic [1:0] {
        BRANCH_OP_NEVER    = 2'd0,
        BRANCH_OP_ZERO     = 2'd1,
        BRANCH_OP_NON_ZERO = 2'd2,
        BRANCH_OP_ALWAYS   = 2'd3
    } branch_op_e;

    typedef enum logic {BRANCH_PC_SRC_IMM = 1'b0, BRANCH_PC_SRC_REG = 1'b1} branch_pc_src_e;

    typedef enum logic [2:0] {
        IMM_FMT_I     = 3'd0,
        IMM_FMT_B     = 3'd1,
        IMM_FMT_U     = 3'd2,
        IMM_FMT_J     = 3'd3,
        IMM_FMT_SHAMT = 3'd4,
        IMM_FMT_NONE  = 3'd5
    } imm_fmt_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic                  alu_sub_sra;   // Subtract, or arithmetic shift.
        alu_src1_e             alu_src1;
        alu_src2_e             alu_src2;
        branch_op_e            branch_op;
        branch_pc_src_e        branch_pc_src;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_writeback;
    } ctrl_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } wb_t;

    localparam ctrl_t CTRL_DEFAULT = '{
        valid:         1'b0,
        alu_op:        ALU_OP_SRC2,
        alu_sub_sra:   1'b0,
        alu_src1:      ALU_SRC1_REG,
        alu_src2:      ALU_SRC2_REG,
        branch_op:     BRANCH_OP_NEVER,
        branch_pc_src: BRANCH_PC_SRC_IMM,
        rd:            '0,
        rd_writeback:  1'b0
    };

endpackage

/* rv32_regs.sv */
module rv32_regs
    import rv32_pkg::*;
(
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  wb_t                   wb_i,
    output logic [XLEN-1:0]       rs1_value_o,
    output logic [XLEN-1:0]       rs2_value_o
);

    logic [XLEN-1:0] regs_q [NUM_REGS];

    // Read port with x0 forced to zero and writeback forwarding.
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_i.en && (wb_i.rd == addr)) begin
            value = wb_i.value;   // Same-edge write wins.
        end else begin
            value = regs_q[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_i.en && (wb_i.rd != '0)) begin
            regs_q[wb_i.rd] <= wb_i.value;
        end
    end

    always_ff @(posedge clk) begin
        rs1_value_o <= read_port(rs1_i);
        rs2_value_o <= read_port(rs2_i);
    end

endmodule

/* rv32_imm_gen.sv */
module rv32_imm_gen
    import rv32_pkg::*;
(
    input  logic [XLEN-1:0] instr_i,
    input  imm_fmt_e        fmt_i,
    output logic [XLEN-1:0] imm_o
);

    logic            sign;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_shamt;

    assign sign      = instr_i[31];
    assign imm_i     = {{21{sign}}, instr_i[30:20]};
    assign imm_b     = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u     = {instr_i[31:12], 12'b0};
    assign imm_j     = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_shamt = {{(XLEN-REG_ADDR_W){1'b0}}, instr_i[24:20]};   // Rs2 field.

    always_comb begin
        case (fmt_i)
            IMM_FMT_I:     imm_o = imm_i;
            IMM_FMT_B:     imm_o = imm_b;
            IMM_FMT_U:     imm_o = imm_u;
            IMM_FMT_J:     imm_o = imm_j;
            IMM_FMT_SHAMT: imm_o = imm_shamt;
            default:       imm_o = '0;
        endcase
    end

endmodule

/* rv32_ctrl_decode.sv */
module rv32_ctrl_decode
    import rv32_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instr_i,
    output imm_fmt_e        imm_fmt_o,
    input  logic [XLEN-1:0] imm_i,
    output ctrl_t           ctrl_o,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] imm_o
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic                  legal;
    alu_op_e               grp_op;
    logic                  grp_sub;
    ctrl_t                 ctrl_d;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd     = instr_i[11:7];

    // *************************************************************************
    // Legal encoding table
    // *************************************************************************
    always_comb begin
        casez ({opcode, funct3, funct7})
            {OPCODE_LUI,    3'b???,         7'b???????},
            {OPCODE_AUIPC,  3'b???,         7'b???????},
            {OPCODE_JAL,    3'b???,         7'b???????},
            {OPCODE_JALR,   FUNCT3_JALR,    7'b???????},
            {OPCODE_BRANCH, FUNCT3_BEQ,     7'b???????},
            {OPCODE_BRANCH, FUNCT3_BNE,     7'b???????},
            {OPCODE_BRANCH, FUNCT3_BLT,     7'b???????},
            {OPCODE_BRANCH, FUNCT3_BGE,     7'b???????},
            {OPCODE_BRANCH, FUNCT3_BLTU,    7'b???????},
            {OPCODE_BRANCH, FUNCT3_BGEU,    7'b???????},
            {OPCODE_OP_IMM, FUNCT3_ADD_SUB, 7'b???????},
            {OPCODE_OP_IMM, FUNCT3_SLT,     7'b???????},
            {OPCODE_OP_IMM, FUNCT3_SLTU,    7'b???????},
            {OPCODE_OP_IMM, FUNCT3_XOR,     7'b???????},
            {OPCODE_OP_IMM, FUNCT3_OR,      7'b???????},
            {OPCODE_OP_IMM, FUNCT3_AND,     7'b???????},
            {OPCODE_OP_IMM, FUNCT3_SLL,     FUNCT7_ZERO},
            {OPCODE_OP_IMM, FUNCT3_SRL_SRA, FUNCT7_ZERO},
            {OPCODE_OP_IMM, FUNCT3_SRL_SRA, FUNCT7_SUB_SRA},
            {OPCODE_OP,     FUNCT3_ADD_SUB, FUNCT7_ZERO},
            {OPCODE_OP,     FUNCT3_ADD_SUB, FUNCT7_SUB_SRA},
            {OPCODE_OP,     FUNCT3_SLL,     FUNCT7_ZERO},
            {OPCODE_OP,     FUNCT3_SLT,     FUNCT7_ZERO},
            {OPCODE_OP,     FUNCT3_SLTU,    FUNCT7_ZERO},
            {OPCODE_OP,     FUNCT3_XOR,     FUNCT7_ZERO},
            {OPCODE_OP,     FUNCT3_SRL_SRA, FUNCT7_ZERO},
            {OPCODE_OP,     FUNCT3_SRL_SRA, FUNCT7_SUB_SRA},
            {OPCODE_OP,     FUNCT3_OR,      FUNCT7_ZERO},
            {OPCODE_OP,     FUNCT3_AND,     FUNCT7_ZERO}: legal = 1'b1;
            default:                                      legal = 1'b0;
        endcase
    end

    // ALU group shared by OP and OP_IMM.
    always_comb begin
        grp_op  = ALU_OP_ADD_SUB;
        grp_sub = 1'b0;
        case (funct3)
            FUNCT3_ADD_SUB: grp_sub = (opcode == OPCODE_OP) && (funct7 == FUNCT7_SUB_SRA);
            FUNCT3_SLL:     grp_op = ALU_OP_SLL;
            FUNCT3_SLT: begin
                grp_op  = ALU_OP_SLT;
                grp_sub = 1'b1;
            end
            FUNCT3_SLTU: begin
                grp_op  = ALU_OP_SLTU;
                grp_sub = 1'b1;
            end
            FUNCT3_XOR:     grp_op = ALU_OP_XOR;
            FUNCT3_SRL_SRA: begin
                grp_op  = ALU_OP_SRL_SRA;
                grp_sub = (funct7 == FUNCT7_SUB_SRA);
            end
            FUNCT3_OR:      grp_op = ALU_OP_OR;
            FUNCT3_AND:     grp_op = ALU_OP_AND;
        endcase
    end

    // *************************************************************************
    // Per-class control
    // *************************************************************************
    always_comb begin
        ctrl_d    = CTRL_DEFAULT;
        imm_fmt_o = IMM_FMT_NONE;
        case (opcode)
            OPCODE_LUI: begin
                ctrl_d.alu_src2     = ALU_SRC2_IMM;   // Pass immediate.
                ctrl_d.rd_writeback = 1'b1;
                imm_fmt_o           = IMM_FMT_U;
            end
            OPCODE_AUIPC: begin
                ctrl_d.alu_op       = ALU_OP_ADD_SUB;
                ctrl_d.alu_src1     = ALU_SRC1_PC;
                ctrl_d.alu_src2     = ALU_SRC2_IMM;
                ctrl_d.rd_writeback = 1'b1;
                imm_fmt_o           = IMM_FMT_U;
            end
            OPCODE_JAL, OPCODE_JALR: begin
                ctrl_d.alu_op       = ALU_OP_SRC1P4;   // Link address.
                ctrl_d.alu_src1     = ALU_SRC1_PC;
                ctrl_d.branch_op    = BRANCH_OP_ALWAYS;
                ctrl_d.rd_writeback = 1'b1;
                if (opcode == OPCODE_JALR) begin
                    ctrl_d.branch_pc_src = BRANCH_PC_SRC_REG;
                    imm_fmt_o            = IMM_FMT_I;
                end else begin
                    imm_fmt_o = IMM_FMT_J;
                end
            end
            OPCODE_BRANCH: begin
                ctrl_d.alu_sub_sra = 1'b1;   // Compare by subtraction.
                imm_fmt_o          = IMM_FMT_B;
                case (funct3)
                    FUNCT3_BEQ, FUNCT3_BNE:   ctrl_d.alu_op = ALU_OP_ADD_SUB;
                    FUNCT3_BLT, FUNCT3_BGE:   ctrl_d.alu_op = ALU_OP_SLT;
                    FUNCT3_BLTU, FUNCT3_BGEU: ctrl_d.alu_op = ALU_OP_SLTU;
                    default: ;
                endcase
                case (funct3)
                    FUNCT3_BNE, FUNCT3_BLT, FUNCT3_BLTU: ctrl_d.branch_op = BRANCH_OP_NON_ZERO;
                    default:                             ctrl_d.branch_op = BRANCH_OP_ZERO;
                endcase
            end
            OPCODE_OP_IMM: begin
                ctrl_d.alu_op       = grp_op;
                ctrl_d.alu_sub_sra  = grp_sub;
                ctrl_d.alu_src2     = ALU_SRC2_IMM;
                ctrl_d.rd_writeback = 1'b1;
                if ((funct3 == FUNCT3_SLL) || (funct3 == FUNCT3_SRL_SRA)) begin
                    imm_fmt_o = IMM_FMT_SHAMT;
                end else begin
                    imm_fmt_o = IMM_FMT_I;
                end
            end
            OPCODE_OP: begin
                ctrl_d.alu_op       = grp_op;
                ctrl_d.alu_sub_sra  = grp_sub;
                ctrl_d.rd_writeback = 1'b1;
            end
            default: ;
        endcase
        if (!legal) begin
            ctrl_d    = CTRL_DEFAULT;
            imm_fmt_o = IMM_FMT_NONE;
        end
        ctrl_d.valid = legal;
        ctrl_d.rd    = rd;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_o <= CTRL_DEFAULT;
            pc_o   <= '0;
            imm_o  <= '0;
        end else begin
            ctrl_o <= ctrl_d;
            pc_o   <= pc_i;
            imm_o  <= imm_i;
        end
    end

endmodule

/* rv32_decode_top.sv */
module rv32_decode_top
    import rv32_pkg::*;
(
    input  logic            clk,
    input  logic            rst_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instr_i,
    input  wb_t             wb_i,
    output ctrl_t           ctrl_o,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] imm_o,
    output logic [XLEN-1:0] rs1_value_o,
    output logic [XLEN-1:0] rs2_value_o
);

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    imm_fmt_e              imm_fmt;
    logic [XLEN-1:0]       imm;

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];

    rv32_regs u_regs (
        .clk         (clk),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .wb_i        (wb_i),
        .rs1_value_o (rs1_value_o),
        .rs2_value_o (rs2_value_o)
    );

    rv32_imm_gen u_imm_gen (
        .instr_i (instr_i),
        .fmt_i   (imm_fmt),
        .imm_o   (imm)
    );

    rv32_ctrl_decode u_ctrl_decode (
        .clk       (clk),
        .rst_i     (rst_i),
        .pc_i      (pc_i),
        .instr_i   (instr_i),
        .imm_fmt_o (imm_fmt),
        .imm_i     (imm),
        .ctrl_o    (ctrl_o),
        .pc_o      (pc_o),
        .imm_o     (imm_o)
    );

endmodule

/* rv32_decode_sva.sv */
module rv32_decode_sva
    import rv32_pkg::*;
(
    input  logic  clk,
    input  logic  rst_i,
    input  ctrl_t ctrl_i
);

    reset_idle: assert property (@(posedge clk) rst_i |=> !ctrl_i.valid)
        else $error("ctrl_o.valid high one cycle after a reset cycle");

    wb_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
        ctrl_i.rd_writeback |-> ctrl_i.valid)
        else $error("rd_writeback set on an invalid decode");

    // Conditional branches never write rd.
    cond_branch_no_wb: assert property (@(posedge clk) disable iff (rst_i)
        ((ctrl_i.branch_op == BRANCH_OP_ZERO) || (ctrl_i.branch_op == BRANCH_OP_NON_ZERO))
        |-> !ctrl_i.rd_writeback)
        else $error("rd_writeback set on a conditional branch");

endmodule

bind rv32_decode_top rv32_decode_sva sva_i (
    .clk    (clk),
    .rst_i  (rst_i),
    .ctrl_i (ctrl_o)
);

/* tb_rv32_decode_top.sv */
module tb_rv32_decode_top
    import rv32_pkg::*;
();

    localparam int          COLS       = 10;
    localparam int          MAX_LINES  = 64;
    localparam int          RST_CYCLES = 2;
    localparam logic [31:0] CTRL_IDLE  = 32'h0000_8000;   // Pass source 2, all else off.

    logic            clk;
    logic            rst_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] instr_i;
    wb_t             wb_i;
    ctrl_t           ctrl_o;
    logic [XLEN-1:0] pc_o;
    logic [XLEN-1:0] imm_o;
    logic [XLEN-1:0] rs1_value_o;
    logic [XLEN-1:0] rs2_value_o;

    logic [31:0] vec [COLS*MAX_LINES];   // One row of COLS words per cycle.
    int          checks;
    int          errors;

    rv32_decode_top dut_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .wb_i        (wb_i),
        .ctrl_o      (ctrl_o),
        .pc_o        (pc_o),
        .imm_o       (imm_o),
        .rs1_value_o (rs1_value_o),
        .rs2_value_o (rs2_value_o)
    );

    always #5 clk = ~clk;

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic string group_name(input int grp);
        case (grp)
            0:       return "reset";
            1:       return "register file";
            2:       return "register-register ops";
            3:       return "immediate ops";
            4:       return "upper and jump ops";
            5:       return "branches";
            6:       return "invalid encodings";
            default: return "unknown group";
        endcase
    endfunction

    task automatic drive_line(input int base);
        pc_i       = vec[base+1];
        instr_i    = vec[base+2];
        wb_i.en    = vec[base+3][0];
        wb_i.rd    = vec[base+4][REG_ADDR_W-1:0];
        wb_i.value = vec[base+5];
    endtask

    task automatic check_line(input int base);
        check_word("pc_o", pc_o, vec[base+1]);   // PC passes straight through.
        check_word("ctrl_o", 32'(ctrl_o), vec[base+6]);
        check_word("imm_o", imm_o, vec[base+7]);
        check_word("rs1_value_o", rs1_value_o, vec[base+8]);
        check_word("rs2_value_o", rs2_value_o, vec[base+9]);
    endtask

    task automatic report_group(input int grp, input int errors_before);
        $display("test %0d %s finished with %0d errors", grp, group_name(grp),
                 errors - errors_before);
    endtask

    initial begin
        int line;
        int base;
        int grp;
        int grp_start;
        int n;
        clk     = 1'b0;
        rst_i   = 1'b1;
        pc_i    = 32'h0000_0ffc;   // Live LUI that reset must mask.
        instr_i = 32'h801053b7;
        wb_i    = '0;
        checks  = 0;
        errors  = 0;
        foreach (vec[k]) begin
            vec[k] = '0;
        end
        $readmemh("rv32_decode_testdata.txt", vec);

        n = 0;
        while (n < RST_CYCLES) begin
            @(negedge clk);
            n++;
        end
        grp_start = errors;
        check_word("ctrl_o", 32'(ctrl_o), CTRL_IDLE);
        check_word("pc_o", pc_o, '0);
        check_word("imm_o", imm_o, '0);
        report_group(0, grp_start);
        rst_i = 1'b0;

        // *********************************************************************
        // Each line is driven and then checked at the next falling edge.
        // *********************************************************************
        line = 0;
        grp  = 0;
        while ((line < MAX_LINES) && (vec[line*COLS] != 0)) begin
            base = line * COLS;
            if (vec[base] != grp) begin
                if (grp != 0) begin
                    report_group(grp, grp_start);
                end
                grp       = vec[base];
                grp_start = errors;
            end
            drive_line(base);
            @(negedge clk);
            check_line(base);
            line++;
        end
        wb_i.en = 1'b0;
        if (grp != 0) begin
            report_group(grp, grp_start);
        end
        if (line == 0) begin
            errors++;
            $display("No stimulus lines could be read from rv32_decode_testdata.txt.");
        end

        $display("Summary: %0d lines, %0d checks, %0d errors", line, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* rv32_decode_top.f */
rv32_pkg.sv
rv32_regs.sv
rv32_imm_gen.sv
rv32_ctrl_decode.sv
rv32_decode_top.sv
rv32_decode_sva.sv
tb_rv32_decode_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rv32_decode_top \
    -f rv32_decode_top.f -o sim_decode \
    && ./obj_dir/sim_decode | tee sim.log \
    && grep -q "^=== PASS ===$" sim.log \
    || { echo "decode stage simulation did not pass"; exit 1; }

/* rv32_decode_testdata.txt */
// grp pc instr wb_en wb_rd wb_value, then expected ctrl imm rs1_value rs2_value
// grp 1 regs, 2 reg-reg, 3 imm, 4 upper and jump, 5 branch, 6 invalid
1 00001000 00008033 1 01 12345678 10001 00000000 12345678 00000000
1 00001004 00208033 1 02 cafef00d 10001 00000000 12345678 cafef00d
1 00001008 00200033 1 00 ffffffff 10001 00000000 00000000 cafef00d
1 0000100c 00000033 1 03 00000005 10001 00000000 00000000 00000000
2 00001010 002082b3 0 00 00000000 1000b 00000000 12345678 cafef00d
2 00001014 402082b3 0 00 00000000 1080b 00000000 12345678 cafef00d
2 00001018 002092b3 0 00 00000000 1100b 00000000 12345678 cafef00d
2 0000101c 0020a2b3 0 00 00000000 1280b 00000000 12345678 cafef00d
2 00001020 0020b2b3 0 00 00000000 1380b 00000000 12345678 cafef00d
2 00001024 0020c2b3 0 00 00000000 1400b 00000000 12345678 cafef00d
2 00001028 0020d2b3 0 00 00000000 1500b 00000000 12345678 cafef00d
2 0000102c 4020d2b3 0 00 00000000 1580b 00000000 12345678 cafef00d
2 00001030 0020e2b3 0 00 00000000 1600b 00000000 12345678 cafef00d
2 00001034 0020f2b3 0 00 00000000 1700b 00000000 12345678 cafef00d
3 00001038 fe008313 0 00 00000000 1020d ffffffe0 12345678 00000000
3 0000103c 8000a313 0 00 00000000 12a0d fffff800 12345678 00000000
3 00001040 8e30c313 0 00 00000000 1420d fffff8e3 12345678 00000005
3 00001044 00309313 0 00 00000000 1120d 00000003 12345678 00000005
3 00001048 0020d313 0 00 00000000 1520d 00000002 12345678 cafef00d
3 0000104c 4010d313 0 00 00000000 15a0d 00000001 12345678 12345678
4 00001050 801053b7 0 00 00000000 1820f 80105000 00000000 12345678
4 00001054 00002397 0 00 00000000 1060f 00002000 00000000 00000000
4 00001058 900003ef 0 00 00000000 1958f fff00100 00000000 00000000
4 0000105c fe0083e7 0 00 00000000 195cf ffffffe0 12345678 00000000
5 00001060 00208863 0 00 00000000 108a0 00000010 12345678 cafef00d
5 00001064 fe209ce3 0 00 00000000 10932 fffffff8 12345678 cafef00d
5 00001068 0020c863 0 00 00000000 12920 00000010 12345678 cafef00d
5 0000106c fe20dce3 0 00 00000000 128b2 fffffff8 12345678 cafef00d
5 00001070 0020e863 0 00 00000000 13920 00000010 12345678 cafef00d
5 00001074 fe20fce3 0 00 00000000 138b2 fffffff8 12345678 cafef00d
6 00001078 40309313 0 00 00000000 0800c 00000000 12345678 00000005
6 0000107c fe0093e7 0 00 00000000 0800e 00000000 12345678 00000000
6 00001080 0000a283 0 00 00000000 0800a 00000000 12345678 00000000
